//--- rtl/issuePkg.sv
`default_nettype none

package issuePkg;

    localparam int PREG_W = 5;
    localparam int DATA_W = 16;
    localparam int ROB_W = 4;

    typedef struct packed {
        logic dir;
        logic [ROB_W-1:0] idx;
    } RobIdx;

    typedef enum logic [1:0] {
        LI,
        ADD,
        SUB,
        XOR
    } AluOp;

    typedef enum logic {
        RUN,
        FLUSH
    } CtrlState;

    typedef struct packed {
        AluOp op;
        logic [PREG_W-1:0] rd;
        logic [PREG_W-1:0] rs1;
        logic [PREG_W-1:0] rs2;
        logic [DATA_W-1:0] imm;
        RobIdx robIdx;
    } MicroOp;

    typedef struct packed {
        AluOp op;
        logic [PREG_W-1:0] rd;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] imm;
        RobIdx robIdx;
    } IssueOp;

    // Shared by writeback and wakeup
    typedef struct packed {
        logic valid;
        logic [PREG_W-1:0] rd;
        logic [DATA_W-1:0] data;
        RobIdx robIdx;
    } WbBus;

    // True when a was allocated after b, a differing dir bit means the index wrapped
    function automatic logic isYounger(RobIdx a, RobIdx b);
        return (a.dir ^ b.dir) ^ (a.idx > b.idx);
    endfunction

endpackage

`default_nettype wire

//--- rtl/issueBank.sv
`default_nettype none

module issueBank #(
    parameter int DEPTH = 8,
    localparam int CNT_W = $clog2(DEPTH + 1)
) (
    input  logic clk,
    input  logic rst,
    input  logic dispValid_i,
    input  issuePkg::MicroOp dispOp_i,
    input  logic src1Ready_i,
    input  logic src2Ready_i,
    input  issuePkg::WbBus wakeup_i,
    input  logic flush_i,
    input  issuePkg::RobIdx flushIdx_i,
    output logic issueValid_o,
    output issuePkg::MicroOp issueOp_o,
    output logic [CNT_W-1:0] freedCount_o
);
    import issuePkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    MicroOp entry [DEPTH];
    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] rdy1;
    logic [DEPTH-1:0] rdy2;
    logic [DEPTH-1:0] ready;
    logic [DEPTH-1:0] younger;
    logic [DEPTH-1:0] freeMask;
    logic [DEPTH-1:0] clearMask;
    logic [IDX_W-1:0] freeIdx;
    logic [IDX_W-1:0] selIdx;
    logic selFound;
    RobIdx selRob;
    logic full;

    assign ready = valid & rdy1 & rdy2;
    assign full = &valid;

    // Lowest invalid entry takes the next dispatch
    always_comb begin
        freeMask = '0;
        freeIdx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                freeIdx = IDX_W'(i);
            end
        end
        freeMask[freeIdx] = ~full;
    end

    always_comb begin
        selFound = 1'b0;
        selIdx = '0;
        selRob = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ready[i] && (!selFound || isYounger(selRob, entry[i].robIdx))) begin
                selFound = 1'b1;
                selIdx = IDX_W'(i);
                selRob = entry[i].robIdx;
            end
        end
    end

    assign issueValid_o = selFound & ~flush_i;
    assign issueOp_o = entry[selIdx];

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            younger[i] = isYounger(entry[i].robIdx, flushIdx_i);
        end
    end

    // A flush frees every younger entry at once, otherwise only the issued one leaves
    always_comb begin
        clearMask = '0;
        if (flush_i) begin
            clearMask = valid & younger;
        end else if (issueValid_o) begin
            clearMask[selIdx] = 1'b1;
        end
    end

    always_comb begin
        freedCount_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            freedCount_o = freedCount_o + CNT_W'(clearMask[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~clearMask) | (dispValid_i ? freeMask : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (dispValid_i) begin
            entry[freeIdx] <= dispOp_i;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (dispValid_i && freeMask[i]) begin
                rdy1[i] <= src1Ready_i;
                rdy2[i] <= src2Ready_i;
            end else begin
                rdy1[i] <= rdy1[i] | (wakeup_i.valid && wakeup_i.rd == entry[i].rs1);
                rdy2[i] <= rdy2[i] | (wakeup_i.valid && wakeup_i.rd == entry[i].rs2);
            end
        end
    end

    // The dispatcher's credit count must keep it out of a full bank
    assert property (@(posedge clk) disable iff (rst) dispValid_i |-> !full)
        else $error("Dispatch into a full issue bank");

    // An older ready entry must still be waiting once the flush cycle is over
    assert property (@(posedge clk) disable iff (rst)
        flush_i && selFound && !younger[selIdx] |=> valid[$past(selIdx)])
        else $error("Issue during flush");

endmodule

`default_nettype wire

//--- rtl/creditCounter.sv
`default_nettype none

module creditCounter #(
    parameter int DEPTH = 8,
    localparam int CNT_W = $clog2(DEPTH + 1)
) (
    input  logic clk,
    input  logic rst,
    input  logic [CNT_W-1:0] freedCount_i,
    output logic creditRet_o
);

    // Wide enough to show an overflow past DEPTH
    localparam int PEND_W = $clog2(2 * DEPTH + 1);

    logic [PEND_W-1:0] pending;

    assign creditRet_o = (pending != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending + PEND_W'(freedCount_i) - PEND_W'(creditRet_o);
        end
    end

    // Bank slots plus credits still held by the dispatcher never exceed DEPTH
    assert property (@(posedge clk) disable iff (rst) pending <= PEND_W'(DEPTH))
        else $error("Pending credits exceed bank depth");

endmodule

`default_nettype wire

//--- rtl/flushCtrl.sv
`default_nettype none

module flushCtrl (
    input  logic clk,
    input  logic rst,
    input  logic redirect_i,
    input  issuePkg::RobIdx redirectIdx_i,
    output logic flush_o,
    output issuePkg::RobIdx flushIdx_o,
    output logic redirectDone_o
);
    import issuePkg::*;

    CtrlState state;
    CtrlState stateNext;
    RobIdx idxQ;

    always_comb begin
        stateNext = state;
        unique case (state)
            RUN: begin
                if (redirect_i) begin
                    stateNext = FLUSH;
                end
            end
            FLUSH: stateNext = RUN;      // Flush always lasts one cycle
            default: stateNext = RUN;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RUN;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == RUN && redirect_i) begin
            idxQ <= redirectIdx_i;
        end
    end

    assign flush_o = (state == FLUSH);
    assign redirectDone_o = (state == FLUSH);
    assign flushIdx_o = idxQ;

    // The dispatcher waits for redirectDone_o before another redirect
    assert property (@(posedge clk) disable iff (rst) state == FLUSH |-> !redirect_i)
        else $error("Redirect received during flush");

endmodule

`default_nettype wire

//--- rtl/physRegFile.sv
`default_nettype none

module physRegFile (
    input  logic clk,
    input  logic rst,
    input  logic [issuePkg::PREG_W-1:0] rs1_i,
    input  logic [issuePkg::PREG_W-1:0] rs2_i,
    output logic [issuePkg::DATA_W-1:0] a_o,
    output logic [issuePkg::DATA_W-1:0] b_o,
    input  logic dispValid_i,
    input  issuePkg::MicroOp dispOp_i,
    output logic src1Ready_o,
    output logic src2Ready_o,
    input  issuePkg::WbBus wb_i
);
    import issuePkg::*;

    localparam int NREG = 1 << PREG_W;

    logic [DATA_W-1:0] regs [NREG];
    logic [NREG-1:0] busy;
    logic hasSrc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Dispatch comes after writeback so a new writer to the same rd stays busy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_i.valid) begin
                busy[wb_i.rd] <= 1'b0;
            end
            if (dispValid_i) begin
                busy[dispOp_i.rd] <= 1'b1;
            end
        end
    end

    assign a_o = (wb_i.valid && wb_i.rd == rs1_i) ? wb_i.data : regs[rs1_i];
    assign b_o = (wb_i.valid && wb_i.rd == rs2_i) ? wb_i.data : regs[rs2_i];

    assign hasSrc = (dispOp_i.op != LI);     // LI reads no registers
    assign src1Ready_o = !hasSrc || !busy[dispOp_i.rs1] ||
                         (wb_i.valid && wb_i.rd == dispOp_i.rs1);
    assign src2Ready_o = !hasSrc || !busy[dispOp_i.rs2] ||
                         (wb_i.valid && wb_i.rd == dispOp_i.rs2);

endmodule

`default_nettype wire

//--- rtl/execPipe.sv
`default_nettype none

module execPipe #(
    parameter int LATENCY = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic issueValid_i,
    input  issuePkg::IssueOp issueOp_i,
    input  logic flush_i,
    input  issuePkg::RobIdx flushIdx_i,
    output issuePkg::WbBus wb_o
);
    import issuePkg::*;

    typedef struct packed {
        logic [PREG_W-1:0] rd;
        logic [DATA_W-1:0] data;
        RobIdx robIdx;
    } StageData;

    logic [DATA_W-1:0] result;
    logic [LATENCY-1:0] stageValid;
    logic [LATENCY-1:0] kill;
    StageData stage [LATENCY];

    always_comb begin
        unique case (issueOp_i.op)
            LI: result = issueOp_i.imm;
            ADD: result = issueOp_i.a + issueOp_i.b;
            SUB: result = issueOp_i.a - issueOp_i.b;
            XOR: result = issueOp_i.a ^ issueOp_i.b;
            default: result = '0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < LATENCY; i++) begin
            kill[i] = flush_i && isYounger(stage[i].robIdx, flushIdx_i);
        end
    end

    // The pipe never stalls, so dropping an op as it moves on is enough
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid[0] <= issueValid_i;
            for (int i = 1; i < LATENCY; i++) begin
                stageValid[i] <= stageValid[i-1] & ~kill[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage[0] <= '{rd: issueOp_i.rd, data: result, robIdx: issueOp_i.robIdx};
        for (int i = 1; i < LATENCY; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    assign wb_o = '{valid: stageValid[LATENCY-1] & ~kill[LATENCY-1],
                    rd: stage[LATENCY-1].rd,
                    data: stage[LATENCY-1].data,
                    robIdx: stage[LATENCY-1].robIdx};

endmodule

`default_nettype wire

//--- rtl/issueTop.sv
`default_nettype none

module issueTop #(
    parameter int DEPTH = 8,
    parameter int LATENCY = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic dispValid_i,
    input  issuePkg::MicroOp dispOp_i,
    input  logic redirect_i,
    input  issuePkg::RobIdx redirectIdx_i,
    output logic creditRet_o,
    output logic redirectDone_o,
    output issuePkg::WbBus wb_o
);
    import issuePkg::*;

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic src1Ready;
    logic src2Ready;
    logic issueValid;
    MicroOp issueSel;
    IssueOp issueOp;
    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opB;
    logic flush;
    RobIdx flushIdx;
    logic [CNT_W-1:0] freedCount;

    issueBank #(.DEPTH(DEPTH)) bank (
        .clk(clk), .rst(rst),
        .dispValid_i(dispValid_i), .dispOp_i(dispOp_i),
        .src1Ready_i(src1Ready), .src2Ready_i(src2Ready),
        .wakeup_i(wb_o),
        .flush_i(flush), .flushIdx_i(flushIdx),
        .issueValid_o(issueValid), .issueOp_o(issueSel),
        .freedCount_o(freedCount)
    );

    creditCounter #(.DEPTH(DEPTH)) credits (
        .clk(clk), .rst(rst),
        .freedCount_i(freedCount),
        .creditRet_o(creditRet_o)
    );

    flushCtrl flushControl (
        .clk(clk), .rst(rst),
        .redirect_i(redirect_i), .redirectIdx_i(redirectIdx_i),
        .flush_o(flush), .flushIdx_o(flushIdx),
        .redirectDone_o(redirectDone_o)
    );

    physRegFile regFile (
        .clk(clk), .rst(rst),
        .rs1_i(issueSel.rs1), .rs2_i(issueSel.rs2),
        .a_o(opA), .b_o(opB),
        .dispValid_i(dispValid_i), .dispOp_i(dispOp_i),
        .src1Ready_o(src1Ready), .src2Ready_o(src2Ready),
        .wb_i(wb_o)
    );

    // Operands join the selected op on its way into the pipe
    assign issueOp = '{op: issueSel.op, rd: issueSel.rd, a: opA, b: opB,
                       imm: issueSel.imm, robIdx: issueSel.robIdx};

    execPipe #(.LATENCY(LATENCY)) pipe (
        .clk(clk), .rst(rst),
        .issueValid_i(issueValid), .issueOp_i(issueOp),
        .flush_i(flush), .flushIdx_i(flushIdx),
        .wb_o(wb_o)
    );

endmodule

`default_nettype wire

//--- sim/issueChecker.sv
`default_nettype none

module issueChecker #(
    parameter int DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic dispValid_i,
    input  issuePkg::MicroOp dispOp_i,
    input  logic redirect_i,
    input  issuePkg::RobIdx redirectIdx_i,
    input  logic creditRet_i,
    input  logic redirectDone_i,
    input  issuePkg::WbBus wb_i,
    input  logic endRun_i,
    output int errors_o,
    output int pending_o,
    output logic reported_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import issuePkg::*;

    localparam int SLOTS = 2 ** (ROB_W + 1);
    localparam int NREG = 2 ** PREG_W;

    typedef enum logic [1:0] {
        FREE,
        PENDING,
        FLUSHED
    } SlotState;

    // One slot per ROB index, dir bit included
    SlotState slotState [SLOTS];
    int slotSeq [SLOTS];
    int slotDep [SLOTS][2];
    logic [DATA_W-1:0] slotData [SLOTS];
    logic [PREG_W-1:0] slotRd [SLOTS];
    logic [DATA_W-1:0] modelReg [NREG];
    int lastWriter [NREG];
    int seqNext;
    int credits;
    int passed;
    int oooCount;
    int redirSeq;
    logic redirWait;
    logic started;

    function automatic logic [DATA_W-1:0] aluModel(AluOp op, logic [DATA_W-1:0] a,
            logic [DATA_W-1:0] b, logic [DATA_W-1:0] imm);
        case (op)
            LI: return imm;
            ADD: return a + b;
            SUB: return a - b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic reportError(input string msg);
        $display("%s", msg);
        errors_o++;
    endtask

    task automatic recordDispatch();
        int s;
        s = int'(dispOp_i.robIdx);
        if (slotState[s] == PENDING) begin
            reportError($sformatf("Error: rob %h dispatched while still in flight", s));
        end
        slotState[s] = PENDING;
        slotSeq[s] = seqNext;
        seqNext++;
        slotRd[s] = dispOp_i.rd;
        slotData[s] = aluModel(dispOp_i.op, modelReg[dispOp_i.rs1], modelReg[dispOp_i.rs2],
                               dispOp_i.imm);
        slotDep[s][0] = (dispOp_i.op == LI) ? -1 : lastWriter[dispOp_i.rs1];
        slotDep[s][1] = (dispOp_i.op == LI) ? -1 : lastWriter[dispOp_i.rs2];
        modelReg[dispOp_i.rd] = slotData[s];     // Program order gives the value consumers see
        lastWriter[dispOp_i.rd] = s;
        pending_o++;
    endtask

    task automatic checkWriteback();
        int s;
        int d;
        logic ok;
        s = int'(wb_i.robIdx);
        ok = 1'b1;
        if (slotState[s] != PENDING) begin
            reportError($sformatf("Error: rob %h written back while %s", wb_i.robIdx,
                        slotState[s] == FLUSHED ? "flushed by a redirect" : "not dispatched"));
            return;
        end
        if (wb_i.rd != slotRd[s]) begin
            reportError($sformatf("Mismatch wb_o.rd rob %h: expected %h, actual %h",
                        wb_i.robIdx, slotRd[s], wb_i.rd));
            ok = 1'b0;
        end
        if (wb_i.data != slotData[s]) begin
            reportError($sformatf("Mismatch wb_o.data rob %h: expected %h, actual %h",
                        wb_i.robIdx, slotData[s], wb_i.data));
            ok = 1'b0;
        end
        for (int k = 0; k < 2; k++) begin
            d = slotDep[s][k];
            if (d >= 0 && slotState[d] == PENDING && slotSeq[d] < slotSeq[s]) begin
                reportError($sformatf("Error: rob %h written back before its producer",
                            wb_i.robIdx));
                ok = 1'b0;
            end
        end
        for (int i = 0; i < SLOTS; i++) begin
            oooCount += int'(slotState[i] == PENDING && slotSeq[i] < slotSeq[s]);
        end
        slotState[s] = FREE;
        pending_o--;
        passed += int'(ok);
        $display("Test op %0d rob %h rd %0d data %h: %s", slotSeq[s], wb_i.robIdx, wb_i.rd,
                 wb_i.data, ok ? "pass" : "fail");
    endtask

    task automatic finishRedirect(input logic timely);
        int flushed;
        flushed = 0;
        if (!timely) begin
            reportError("Error: redirect done without a redirect one cycle earlier");
        end
        for (int i = 0; i < SLOTS; i++) begin
            if (slotState[i] == PENDING && slotSeq[i] > redirSeq) begin
                slotState[i] = FLUSHED;
                flushed++;
            end
        end
        pending_o -= flushed;
        passed += int'(timely);
        $display("Test redirect after op %0d: %0d ops flushed: %s", redirSeq, flushed,
                 timely ? "pass" : "fail");
    endtask

    task automatic finalReport();
        if (pending_o != 0) begin
            reportError($sformatf("Error: %0d ops were never written back", pending_o));
        end
        if (credits != DEPTH) begin
            reportError($sformatf("Error: dispatcher holds %0d credits after the drain, not %0d",
                        credits, DEPTH));
        end
        if (oooCount == 0) begin
            reportError("Error: no op was written back ahead of an older waiting op");
        end
        $display("Summary: %0d tests passed, %0d errors", passed, errors_o);
        reported_o = 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SLOTS; i++) begin
                slotState[i] = FREE;
            end
            for (int i = 0; i < NREG; i++) begin
                modelReg[i] = '0;
                lastWriter[i] = -1;
            end
            seqNext = 0;
            credits = DEPTH;
            passed = 0;
            oooCount = 0;
            redirSeq = 0;
            redirWait = 1'b0;
            started = 1'b0;
            errors_o = 0;
            pending_o = 0;
            reported_o = 1'b0;
        end else begin
            if (!started && (wb_i.valid || creditRet_i || redirectDone_i)) begin
                reportError("Error: an output went high before any dispatch or redirect");
            end
            started = started | dispValid_i | redirect_i;
            if (wb_i.valid) begin
                checkWriteback();
            end
            if (redirectDone_i) begin
                finishRedirect(redirWait);
            end else if (redirWait) begin
                reportError("Error: redirect done did not follow the redirect by one cycle");
            end
            redirWait = redirect_i;
            if (redirect_i) begin
                redirSeq = slotSeq[int'(redirectIdx_i)];
            end
            if (dispValid_i) begin
                recordDispatch();
                credits--;
            end
            if (creditRet_i) begin
                credits++;
            end
            if (credits > DEPTH || credits < 0) begin
                reportError($sformatf("Error: dispatcher credit count %0d is outside 0 to %0d",
                            credits, DEPTH));
            end
            if (endRun_i && !reported_o) begin
                finalReport();
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/issueTb.sv
`default_nettype none

module issueTb;
    timeunit 1ns;
    timeprecision 1ps;
    import issuePkg::*;

    localparam int DEPTH = 8;
    localparam int LATENCY = 2;
    localparam int ROWS = 15;
    localparam int WATCHDOG_CYCLES = ROWS * (DEPTH + LATENCY + 8) + 20;

    typedef struct packed {
        MicroOp uop;
        logic redirect;
        RobIdx redirIdx;
    } StimRow;

    logic clk;
    logic rst;
    logic dispValid;
    MicroOp dispOp;
    logic redirect;
    RobIdx redirectIdx;
    logic creditRet;
    logic redirectDone;
    WbBus wb;
    logic endRun;
    int errors;
    int outstanding;
    logic reported;
    StimRow stim [ROWS];
    logic [ROB_W:0] robNext;
    int sent;
    int returned;
    int seed;

    issueTop #(.DEPTH(DEPTH), .LATENCY(LATENCY)) dut_i (
        .clk(clk), .rst(rst),
        .dispValid_i(dispValid), .dispOp_i(dispOp),
        .redirect_i(redirect), .redirectIdx_i(redirectIdx),
        .creditRet_o(creditRet), .redirectDone_o(redirectDone),
        .wb_o(wb)
    );

    issueChecker #(.DEPTH(DEPTH)) scoreboard (
        .clk(clk), .rst(rst),
        .dispValid_i(dispValid), .dispOp_i(dispOp),
        .redirect_i(redirect), .redirectIdx_i(redirectIdx),
        .creditRet_i(creditRet), .redirectDone_i(redirectDone),
        .wb_i(wb), .endRun_i(endRun),
        .errors_o(errors), .pending_o(outstanding), .reported_o(reported)
    );

    // The ROB index of an op row is assigned when it is dispatched
    function automatic StimRow opRow(AluOp op, int rd, int rs1, int rs2, int imm);
        StimRow row;
        row = '0;
        row.uop.op = op;
        row.uop.rd = PREG_W'(rd);
        row.uop.rs1 = PREG_W'(rs1);
        row.uop.rs2 = PREG_W'(rs2);
        row.uop.imm = DATA_W'(imm);
        return row;
    endfunction

    function automatic StimRow redirRow(int idx);
        StimRow row;
        row = '0;
        row.redirect = 1'b1;
        row.redirIdx = (ROB_W + 1)'(idx);
        return row;
    endfunction

    task automatic dispatchOp(input MicroOp uop);
        MicroOp op;
        op = uop;
        while (sent - returned >= DEPTH) begin
            @(negedge clk);
        end
        op.robIdx = robNext;
        dispValid = 1'b1;
        dispOp = op;
        sent++;
        robNext = robNext + (ROB_W + 1)'(1);
        @(negedge clk);
        dispValid = 1'b0;
    endtask

    task automatic applyRedirect(input RobIdx idx);
        redirect = 1'b1;
        redirectIdx = idx;
        @(negedge clk);
        redirect = 1'b0;
        while (!redirectDone) begin
            @(negedge clk);
        end
        @(negedge clk);
        robNext = {idx.dir, idx.idx} + (ROB_W + 1)'(1);    // Younger indices are free again
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            returned <= 0;
        end else if (creditRet) begin
            returned <= returned + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        int gap;
        rst = 1'b1;
        dispValid = 1'b0;
        dispOp = '0;
        redirect = 1'b0;
        redirectIdx = '0;
        endRun = 1'b0;
        robNext = '0;
        sent = 0;
        seed = 96849;
        stim[0] = opRow(LI, 1, 0, 0, 'h0005);
        stim[1] = opRow(LI, 2, 0, 0, 'h0003);
        stim[2] = opRow(ADD, 3, 1, 2, 0);
        stim[3] = opRow(SUB, 4, 3, 2, 0);
        stim[4] = opRow(XOR, 5, 4, 1, 0);
        stim[5] = opRow(ADD, 6, 5, 3, 0);
        stim[6] = opRow(LI, 7, 0, 0, 'h1234);     // Ready at once, overtakes the chain above
        stim[7] = opRow(XOR, 8, 7, 6, 0);
        stim[8] = opRow(ADD, 9, 8, 4, 0);
        stim[9] = opRow(SUB, 10, 9, 7, 0);
        stim[10] = redirRow(7);                   // Drops ops 8 and 9 if still in flight
        stim[11] = opRow(LI, 11, 0, 0, 'hbeef);
        stim[12] = opRow(SUB, 12, 11, 6, 0);
        stim[13] = opRow(ADD, 13, 12, 7, 0);
        stim[14] = opRow(XOR, 14, 13, 11, 0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Idle cycles let the checker watch the outputs after reset
        repeat (4) @(negedge clk);
        for (int r = 0; r < ROWS; r++) begin
            gap = $random(seed) & 1;
            repeat (gap) @(negedge clk);
            if (stim[r].redirect) begin
                applyRedirect(stim[r].redirIdx);
            end else begin
                dispatchOp(stim[r].uop);
            end
        end
        while (returned != sent || outstanding != 0) begin
            @(negedge clk);
        end
        endRun = 1'b1;
        wait (reported);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
rtl/issuePkg.sv
rtl/issueBank.sv
rtl/creditCounter.sv
rtl/flushCtrl.sv
rtl/physRegFile.sv
rtl/execPipe.sv
rtl/issueTop.sv
sim/issueChecker.sv
sim/issueTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps -Wall
TOP = issueTb
FILELIST = compile.f

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
